/* run_sim.sh */
#!/bin/sh
# build the control endpoint testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_usb_dfu_ctrl_ep --Mdir obj_dir -o tb_sim -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sources.f */
+incdir+verilog
verilog/usb_ctrl_pkg.sv
verilog/setup_capture.sv
verilog/ctrl_xfer_fsm.sv
verilog/request_decoder.sv
verilog/dfu_status_regs.sv
verilog/descriptor_rom.sv
verilog/usb_dfu_ctrl_ep.sv
testbench/tb_usb_dfu_ctrl_ep.sv

/* testbench/ctrl_vectors.txt */
# name, setup bytes 0..7 (hex, wLength in bytes 6 and 7), in bytes (dec),
# xor of in bytes (hex), stall (dec), dev_addr after the transfer (hex)
dfu_getstatus        a1 03 00 00 00 00 06 00   6 03 0 00
dfu_getstate         a1 05 00 00 00 00 01 00   1 02 0 00
get_dev_desc         80 06 00 01 00 00 40 00  18 2f 0 00
get_dev_desc_8       80 06 00 01 00 00 08 00   8 32 0 00
get_conf_desc        80 06 00 02 00 00 ff 00  27 da 0 00
get_lang_string      80 06 00 03 00 00 ff 00   4 0a 0 00
get_string_2         80 06 02 03 09 04 ff 00  26 72 0 00
set_address          00 05 2a 00 00 00 00 00   0 00 0 2a
set_config           00 09 01 00 00 00 00 00   0 00 0 2a
dfu_dnload           21 01 00 00 00 00 40 00   0 00 1 2a
status_after_dnload  a1 03 00 00 00 00 06 00   6 08 0 2a
dfu_clrstatus        21 04 00 00 00 00 00 00   0 00 0 2a
state_after_clr      a1 05 00 00 00 00 01 00   1 02 0 2a
status_after_clr     a1 03 00 00 00 00 06 00   6 03 0 2a
get_status_std       80 00 00 00 00 00 02 00   0 00 1 2a
get_dev_qualifier    80 06 00 06 00 00 0a 00   0 00 1 2a
get_dev_after_stall  80 06 00 01 00 00 40 00  18 2f 0 2a

/* testbench/tb_usb_dfu_ctrl_ep.sv */
`default_nettype none

module tb_usb_dfu_ctrl_ep;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [63:0] setup;     // byte 0 in the low bits
    logic [15:0] count;
    logic [7:0]  xor_sum;
    logic        stall;
    logic [6:0]  addr;
  } vector_t;

  localparam int WAIT_LIMIT = 400;   // cycles

  logic       clk;
  logic       reset;
  logic [6:0] dev_addr;
  logic       out_ep_req;
  logic       out_ep_grant;
  logic       out_ep_data_avail;
  logic       out_ep_setup;
  logic       out_ep_data_get;
  logic [7:0] out_ep_data;
  logic       out_ep_acked;
  logic       in_ep_req;
  logic       in_ep_grant;
  logic       in_ep_data_free;
  logic       in_ep_data_put;
  logic [7:0] in_ep_data;
  logic       in_ep_data_done;
  logic       in_ep_stall;
  logic       in_ep_acked;

  logic [31:0] rnd_state;
  string       test_name;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  usb_dfu_ctrl_ep u_dut (
    .clk, .reset, .dev_addr,
    .out_ep_req, .out_ep_grant, .out_ep_data_avail, .out_ep_setup, .out_ep_data_get,
    .out_ep_data, .out_ep_acked,
    .in_ep_req, .in_ep_grant, .in_ep_data_free, .in_ep_data_put, .in_ep_data,
    .in_ep_data_done, .in_ep_stall, .in_ep_acked
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0s: %0s expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
      errors++;
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // host side of the out endpoint
  ////////////////////////////////////////////////////////////

  task automatic send_setup(input logic [63:0] pkt);
    int i;
    next_cycle();
    out_ep_data_avail = 1'b1;
    out_ep_setup      = 1'b1;
    out_ep_grant      = 1'b1;
    // a granted byte is presented one cycle later
    for (i = 0; i < 7; i++) begin
      next_cycle();
      out_ep_data = pkt[8*i +: 8];
      @(negedge clk);
      check_value("out_ep_req, out_ep_data_get", 32'h3, 32'({out_ep_req, out_ep_data_get}));
    end
    next_cycle();
    out_ep_data       = pkt[63:56];
    out_ep_data_avail = 1'b0;
    out_ep_grant      = 1'b0;
    @(negedge clk);
    check_value("out_ep_req, out_ep_data_get", 32'h0, 32'({out_ep_req, out_ep_data_get}));
    next_cycle();
    out_ep_setup = 1'b0;
    out_ep_data  = 8'h00;
  endtask

  task automatic run_vector(input vector_t v, input logic [6:0] prev_addr);
    int         cyc;
    int         count;
    int         errors_before;
    logic [7:0] xor_sum;
    logic       done_seen;
    logic       stall_seen;
    errors_before = errors;
    count         = 0;
    xor_sum       = 8'h00;
    done_seen     = 1'b0;
    stall_seen    = 1'b0;
    send_setup(v.setup);

    // data stage, free drops about one cycle in four
    cyc = 0;
    while (!done_seen && !stall_seen && cyc < WAIT_LIMIT) begin
      next_cycle();
      rnd_state       = xorshift32(rnd_state);
      in_ep_grant     = 1'b1;
      in_ep_data_free = (rnd_state[1:0] != 2'b00);
      @(negedge clk);
      check_value("put while not free", 32'd0, 32'(in_ep_data_put && !in_ep_data_free));
      check_value("put without req", 32'd0, 32'(in_ep_data_put && !in_ep_req));
      if (in_ep_data_put && in_ep_grant) begin
        count++;
        xor_sum ^= in_ep_data;
      end
      done_seen  = in_ep_data_done;
      stall_seen = in_ep_stall;
      cyc++;
    end

    if (!done_seen && !stall_seen) begin
      $display("timeout: %0s saw neither in_ep_data_done nor in_ep_stall", test_name);
      timed_out = 1'b1;
      errors++;
    end else begin
      if (done_seen) begin
        // new address only after the status stage
        check_value("dev_addr at status start", 32'(prev_addr), 32'(dev_addr));
        next_cycle();
        in_ep_grant = 1'b0;
        in_ep_acked = 1'b1;
        @(negedge clk);
        stall_seen = in_ep_stall;
        next_cycle();
        in_ep_acked = 1'b0;
        if (v.setup[63:48] != 16'd0 && !stall_seen) begin
          out_ep_acked = 1'b1;   // zero length out status
          next_cycle();
          out_ep_acked = 1'b0;
        end
      end
      in_ep_grant     = 1'b0;
      in_ep_data_free = 1'b1;
      repeat (2) next_cycle();
      @(negedge clk);
      check_value("in byte count", 32'(v.count), 32'(count));
      check_value("in byte xor", 32'(v.xor_sum), 32'(xor_sum));
      check_value("stall", 32'(v.stall), 32'(stall_seen));
      check_value("dev_addr", 32'(v.addr), 32'(dev_addr));
    end

    tests_run++;
    if (errors == errors_before) begin
      $display("test %0s ok", test_name);
    end else begin
      $display("test %0s failed", test_name);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int              fd;
    int              n;
    int              i;
    int              cnt;
    int              xs;
    int              st;
    int              ad;
    string           line;
    logic [8*24-1:0] name_buf;
    logic [7:0]      sb [8];
    vector_t         v;
    logic [6:0]      prev_addr;

    reset             = 1'b1;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b0;
    in_ep_data_free   = 1'b1;
    in_ep_acked       = 1'b0;
    rnd_state         = 32'h5a0b1fb5;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    timed_out         = 1'b0;
    prev_addr         = 7'd0;
    test_name         = "reset_values";

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // endpoint outputs idle after reset
    @(negedge clk);
    check_value("in_ep_req after reset", 32'd0, 32'(in_ep_req));
    check_value("in_ep_data_put after reset", 32'd0, 32'(in_ep_data_put));
    check_value("in_ep_data_done after reset", 32'd0, 32'(in_ep_data_done));
    check_value("in_ep_stall after reset", 32'd0, 32'(in_ep_stall));
    check_value("dev_addr after reset", 32'd0, 32'(dev_addr));

    fd = $fopen("testbench/ctrl_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/ctrl_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // skip comments
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %h %d %h", name_buf,
                      sb[0], sb[1], sb[2], sb[3], sb[4], sb[5], sb[6], sb[7],
                      cnt, xs, st, ad);
          if (n != 13) begin
            $display("malformed line in the vector file: %0s", line);
            errors++;
          end else begin
            test_name = $sformatf("%0s", name_buf);
            for (i = 0; i < 8; i++) begin
              v.setup[8*i +: 8] = sb[i];
            end
            v.count   = cnt[15:0];
            v.xor_sum = xs[7:0];
            v.stall   = st[0];
            v.addr    = ad[6:0];
            run_vector(v, prev_addr);
            prev_addr = v.addr;
          end
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out && tests_run > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ctrl_xfer_fsm.sv */
`default_nettype none

module ctrl_xfer_fsm import usb_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  setup_pkt_t  setup,
  input  logic        setup_start,
  input  logic        pkt_end,
  input  logic        out_ep_acked,
  input  logic        in_ep_acked,
  input  logic        in_ep_grant,
  input  logic        in_ep_data_free,
  input  logic        out_ep_grant,
  input  logic        out_ep_data_avail,
  input  logic [15:0] rom_length,
  input  logic        in_ep_stall,
  output ctrl_state_e state,
  output logic        setup_stage_end,
  output logic        status_stage_end,
  output logic        in_ep_req,
  output logic        in_ep_data_put,
  output logic        in_ep_data_done
);

  ctrl_state_e state_next;
  logic [15:0] data_left;
  logic        has_data;
  logic        all_sent;
  logic        all_sent_q;
  logic        zlp_done;     // zero length packet for the status stage
  logic        in_byte;
  logic        out_byte;

  assign has_data = |setup.w_length;
  assign all_sent = (state == data_in) && ((rom_length == 16'd0) || (data_left == 16'd0));
  assign in_byte  = in_ep_data_put && in_ep_grant;
  assign out_byte = (state == data_out) && out_ep_data_avail && out_ep_grant
                    && (data_left != 16'd0);

  assign in_ep_req       = (state == data_in) && !all_sent;
  assign in_ep_data_put  = in_ep_req && in_ep_data_free;
  assign in_ep_data_done = zlp_done || (all_sent && !all_sent_q && !in_ep_stall);

  ////////////////////////////////////////////////////////////
  // stage sequencing
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next       = state;
    setup_stage_end  = 1'b0;
    status_stage_end = 1'b0;
    zlp_done         = 1'b0;
    case (state)
      idle:     if (setup_start) state_next = setup_in;
      setup_in: if (pkt_end) state_next = setup_done;
      setup_done: begin
        setup_stage_end = 1'b1;
        if (!has_data) begin
          state_next = status_in;
          zlp_done   = 1'b1;
        end else if (setup.bm_request_type[7]) begin
          state_next = data_in;   // device to host
        end else begin
          state_next = data_out;
        end
      end
      data_in: begin
        if (in_ep_stall) begin
          state_next       = idle;
          status_stage_end = 1'b1;
        end else if (in_ep_acked && all_sent) begin
          state_next = status_out;
        end
      end
      data_out: begin
        if (in_ep_stall) begin
          state_next       = idle;
          status_stage_end = 1'b1;
        end else if (out_ep_acked && data_left == 16'd0) begin
          state_next = status_in;
          zlp_done   = 1'b1;
        end
      end
      status_in: begin
        if (in_ep_stall || in_ep_acked) begin
          state_next       = idle;
          status_stage_end = 1'b1;
        end
      end
      status_out: begin
        if (out_ep_acked) begin
          state_next       = idle;
          status_stage_end = 1'b1;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      data_left  <= 16'd0;
      all_sent_q <= 1'b0;
    end else begin
      state      <= state_next;
      all_sent_q <= all_sent;
      if (setup_stage_end) begin
        data_left <= setup.w_length;
      end else if (in_byte || out_byte) begin
        data_left <= data_left - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/descriptor_rom.sv */
`default_nettype none

`include "usb_ctrl_defines.svh"

module descriptor_rom import usb_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  rom_sel_t   rom_sel,
  input  logic       setup_stage_end,
  input  logic       byte_sent,
  input  logic [7:0] status_byte,
  output logic [2:0] status_addr,
  output logic [7:0] in_ep_data
);

  localparam int EP_ROM_LEN = `LANG_DESC_ADDR + 4;

  ////////////////////////////////////////////////////////////
  // endpoint descriptor table
  ////////////////////////////////////////////////////////////
  localparam logic [7:0] EP_ROM [EP_ROM_LEN] = '{
    // device
    8'd18, 8'd1, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'(`MAX_PACKET_SIZE),
    8'h50, 8'h1d, 8'h30, 8'h61, 8'h00, 8'h00, 8'd1, 8'd2, 8'd3, 8'd1,
    // configuration, self powered
    8'd9, 8'd2, 8'(`CONF_TOTAL_LEN), 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,
    // interface, DFU mode protocol
    8'd9, 8'd4, 8'd0, 8'd0, 8'd0, 8'hfe, 8'd1, 8'd2, 8'd4,
    // DFU functional
    8'd9, 8'h21, 8'h0b, 8'd255, 8'd0,
    8'(`DFU_TRANSFER_SIZE % 256), 8'(`DFU_TRANSFER_SIZE / 256), 8'h10, 8'h01,
    // language ids, US English
    8'd4, 8'd3, 8'h09, 8'h04
  };

  logic [7:0] offset;   // bytes sent in this data stage
  logic [7:0] rd_addr;

  // UTF-16 string slots built from ascii text
  function automatic logic [7:0] str_byte(input logic [1:0] slot, input logic [4:0] ofs);
    logic [95:0] text;
    logic [7:0]  len;
    logic [3:0]  n;
    logic [3:0]  i;
    case (slot)
      2'd0:    text = "Lattice";
      2'd1:    text = "TinyDFU Boot";
      2'd2:    text = "123456";
      default: text = "Flash";
    endcase
    len = str_desc_len({6'd0, slot} + 8'd1);
    n = 4'((len - 8'd2) >> 1);
    i = 4'(ofs >> 1) - 4'd1;
    if (ofs == 5'd0) return len;
    else if (ofs == 5'd1) return 8'd3;   // STRING type
    else if (ofs >= len || ofs[0]) return 8'd0;
    else return text[8*(n-1-i) +: 8];
  endfunction

  always_ff @(posedge clk) begin
    if (reset || setup_stage_end) begin
      offset <= 8'd0;
    end else if (byte_sent) begin
      offset <= offset + 8'd1;
    end
  end

  assign rd_addr     = rom_sel.addr + offset;
  assign status_addr = rd_addr[2:0];

  always_comb begin
    case (rom_sel.src)
      src_endpoint:   in_ep_data = (rd_addr < EP_ROM_LEN) ? EP_ROM[rd_addr[5:0]] : 8'h00;
      src_string:     in_ep_data = str_byte(2'(rd_addr / `STRING_SLOT_SIZE),
                                            5'(rd_addr % `STRING_SLOT_SIZE));
      src_dfu_status: in_ep_data = status_byte;
      default:        in_ep_data = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/dfu_status_regs.sv */
`default_nettype none

module dfu_status_regs import usb_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  dfu_cmd_e   dfu_cmd,
  input  logic [2:0] status_addr,
  output logic [7:0] status_byte,
  output dfu_state_e dfu_state
);

  dfu_status_e status;

  always_ff @(posedge clk) begin
    if (reset) begin
      status    <= ok;
      dfu_state <= dfu_idle;
    end else begin
      case (dfu_cmd)
        cmd_refuse: begin
          status    <= err_write;
          dfu_state <= dfu_error;
        end
        cmd_clrstatus: begin
          status    <= ok;
          dfu_state <= dfu_idle;
        end
        cmd_abort: dfu_state <= dfu_idle;
        default: ;
      endcase
    end
  end

  // status record: bStatus, bwPollTimeout[3], bState, iString
  always_comb begin
    case (status_addr)
      3'd0:    status_byte = status;
      3'd1:    status_byte = 8'd1;   // 1 ms poll timeout
      3'd4:    status_byte = dfu_state;
      default: status_byte = 8'd0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/request_decoder.sv */
`default_nettype none

`include "usb_ctrl_defines.svh"

module request_decoder import usb_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  setup_pkt_t setup,
  input  logic       setup_stage_end,
  input  logic       status_stage_end,
  input  logic       byte_sent,
  input  dfu_state_e dfu_state,
  output rom_sel_t   rom_sel,
  output dfu_cmd_e   dfu_cmd,
  output logic       in_ep_stall,
  output logic [6:0] dev_addr
);

  rom_sel_t   sel_next;
  dfu_cmd_e   cmd_next;
  logic       stall_next;
  logic       addr_save;
  logic       addr_pending;
  logic [6:0] pending_addr;
  logic [7:0] str_idx;
  logic [7:0] str_len;

  assign str_idx = setup.w_value[7:0];
  assign str_len = str_desc_len(str_idx);

  always_comb begin
    sel_next   = '{src_endpoint, 8'd0, 16'd0};   // no data stage
    cmd_next   = cmd_none;
    stall_next = 1'b0;
    addr_save  = 1'b0;
    case ({setup.bm_request_type[6:5], setup.b_request})
      10'h006: begin   // GET_DESCRIPTOR
        case (setup.w_value[15:8])
          8'd1: sel_next = '{src_endpoint, 8'(`DEV_DESC_ADDR), 16'd18};
          8'd2: sel_next = '{src_endpoint, 8'(`CONF_DESC_ADDR), 16'(`CONF_TOTAL_LEN)};
          8'd3: begin
            if (str_idx == 8'd0) begin
              sel_next = '{src_endpoint, 8'(`LANG_DESC_ADDR), 16'd4};
            end else if (str_len != 8'd0) begin
              sel_next = '{src_string, 8'((str_idx - 8'd1) * `STRING_SLOT_SIZE),
                           {8'd0, str_len}};
            end else begin
              stall_next = 1'b1;
            end
          end
          default: stall_next = 1'b1;   // qualifier and the rest
        endcase
      end
      10'h005: addr_save = 1'b1;   // SET_ADDRESS
      10'h009, 10'h00b: ;          // SET_CONFIGURATION, SET_INTERFACE
      10'h101, 10'h102: begin      // DNLOAD / UPLOAD, no flash behind us
        cmd_next   = cmd_refuse;
        stall_next = 1'b1;
      end
      10'h103: begin
        sel_next = '{src_dfu_status, 8'd0, 16'(`DFU_STATUS_LEN)};
        cmd_next = cmd_getstatus;
      end
      10'h104: cmd_next = cmd_clrstatus;
      10'h105: sel_next = '{src_dfu_status, 8'd4, 16'd1};   // bState only
      10'h106: begin
        // abort is not accepted in dfu_error
        if (dfu_state == dfu_error) stall_next = 1'b1;
        else cmd_next = cmd_abort;
      end
      default: stall_next = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rom_sel      <= '0;
      dfu_cmd      <= cmd_none;
      in_ep_stall  <= 1'b0;
      addr_pending <= 1'b0;
      dev_addr     <= 7'd0;
    end else begin
      dfu_cmd     <= cmd_none;
      in_ep_stall <= 1'b0;
      if (setup_stage_end) begin
        rom_sel     <= sel_next;
        dfu_cmd     <= cmd_next;
        in_ep_stall <= stall_next;
        if (addr_save) addr_pending <= 1'b1;
      end else if (byte_sent) begin
        rom_sel.length <= rom_sel.length - 16'd1;
      end
      // status token still uses the old address
      if (status_stage_end && addr_pending) begin
        dev_addr     <= pending_addr;
        addr_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_stage_end && addr_save) pending_addr <= setup.w_value[6:0];
  end

endmodule

`default_nettype wire

/* verilog/setup_capture.sv */
`default_nettype none

`include "usb_ctrl_defines.svh"

module setup_capture import usb_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  input  logic       out_ep_grant,
  input  logic [7:0] out_ep_data,
  input  logic       status_stage_end,
  output setup_pkt_t setup,
  output logic       setup_start,
  output logic       pkt_end
);

  logic                       avail_q;
  logic                       setup_byte_q;   // a setup byte is on out_ep_data
  logic [3:0]                 byte_cnt;
  logic [8*`SETUP_BYTES-1:0]  setup_raw;
  logic                       byte_wr;

  assign byte_wr = setup_byte_q && (byte_cnt < `SETUP_BYTES);

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q      <= 1'b0;
      setup_start  <= 1'b0;
      pkt_end      <= 1'b0;
      setup_byte_q <= 1'b0;
      byte_cnt     <= 4'd0;
    end else begin
      avail_q      <= out_ep_data_avail;
      setup_start  <= out_ep_data_avail && !avail_q && out_ep_setup;
      pkt_end      <= avail_q && !out_ep_data_avail;
      setup_byte_q <= out_ep_data_avail && out_ep_grant && out_ep_setup;
      if (status_stage_end) begin
        byte_cnt <= 4'd0;   // ready for the next transfer
      end else if (byte_wr) begin
        byte_cnt <= byte_cnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_wr) begin
      setup_raw[byte_cnt[2:0]*8 +: 8] <= out_ep_data;
    end
  end

  assign setup = setup_pkt_t'(setup_raw);

endmodule

`default_nettype wire

/* verilog/usb_ctrl_defines.svh */
`ifndef USB_CTRL_DEFINES_SVH
`define USB_CTRL_DEFINES_SVH

// endpoint 0 packet size and DFU block size
`define MAX_PACKET_SIZE    32
`define DFU_TRANSFER_SIZE  256

// byte offsets inside the endpoint descriptor table
`define DEV_DESC_ADDR      0
`define CONF_DESC_ADDR     18
`define LANG_DESC_ADDR     45

`define CONF_TOTAL_LEN     27   // config + interface + dfu functional

`define STRING_SLOT_SIZE   32   // bytes reserved per string descriptor

`define SETUP_BYTES        8
`define DFU_STATUS_LEN     6

`endif

/* verilog/usb_ctrl_pkg.sv */
`default_nettype none

package usb_ctrl_pkg;

  typedef enum logic [2:0] {
    idle, setup_in, setup_done, data_in, data_out, status_in, status_out
  } ctrl_state_e;

  typedef enum logic [1:0] {
    src_endpoint, src_string, src_dfu_status
  } rom_src_e;

  typedef enum logic [7:0] {
    app_idle, app_detach, dfu_idle, dfu_dnload_sync, dfu_dnbusy, dfu_dnload_idle,
    dfu_manifest_sync, dfu_manifest, dfu_manifest_wait_reset, dfu_upload_idle, dfu_error
  } dfu_state_e;

  typedef enum logic [7:0] {
    ok, err_target, err_file, err_write, err_erase, err_check_erased, err_prog,
    err_verify, err_address, err_notdone, err_firmware, err_vendor, err_usbr,
    err_por, err_unknown, err_stalledpkt
  } dfu_status_e;

  typedef enum logic [2:0] {
    cmd_none, cmd_clrstatus, cmd_abort, cmd_getstatus, cmd_refuse
  } dfu_cmd_e;

  // byte 0 of the packet sits in the low bits
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_pkt_t;

  typedef struct packed {
    rom_src_e    src;
    logic [7:0]  addr;
    logic [15:0] length;
  } rom_sel_t;

  // bLength of string descriptors 1..4, 0 when no such string
  function automatic logic [7:0] str_desc_len(input logic [7:0] idx);
    case (idx)
      8'd1:    return 8'd16;   // "Lattice"
      8'd2:    return 8'd26;   // "TinyDFU Boot"
      8'd3:    return 8'd14;   // "123456"
      8'd4:    return 8'd12;   // "Flash"
      default: return 8'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* verilog/usb_dfu_ctrl_ep.sv */
`default_nettype none

module usb_dfu_ctrl_ep import usb_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic [6:0] dev_addr,

  ////////////////////////////////////////////////////////////
  // out endpoint
  ////////////////////////////////////////////////////////////
  output logic       out_ep_req,
  input  logic       out_ep_grant,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  output logic       out_ep_data_get,
  input  logic [7:0] out_ep_data,
  input  logic       out_ep_acked,

  ////////////////////////////////////////////////////////////
  // in endpoint
  ////////////////////////////////////////////////////////////
  output logic       in_ep_req,
  input  logic       in_ep_grant,
  input  logic       in_ep_data_free,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  input  logic       in_ep_acked
);

  setup_pkt_t setup;
  logic       setup_start;
  logic       pkt_end;
  logic       setup_stage_end;
  logic       status_stage_end;
  logic       byte_sent;
  rom_sel_t   rom_sel;
  dfu_cmd_e   dfu_cmd;
  dfu_state_e dfu_state;
  logic [7:0] status_byte;
  logic [2:0] status_addr;

  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_data_get = out_ep_data_avail;   // always drain the out fifo
  assign byte_sent       = in_ep_data_put && in_ep_grant;

  setup_capture u_setup_capture (
    .clk, .reset, .out_ep_data_avail, .out_ep_setup, .out_ep_grant, .out_ep_data,
    .status_stage_end, .setup, .setup_start, .pkt_end
  );

  ctrl_xfer_fsm u_ctrl_xfer_fsm (
    .clk, .reset, .setup, .setup_start, .pkt_end, .out_ep_acked, .in_ep_acked,
    .in_ep_grant, .in_ep_data_free, .out_ep_grant, .out_ep_data_avail,
    .rom_length(rom_sel.length), .in_ep_stall, .state(), .setup_stage_end,
    .status_stage_end, .in_ep_req, .in_ep_data_put, .in_ep_data_done
  );

  request_decoder u_request_decoder (
    .clk, .reset, .setup, .setup_stage_end, .status_stage_end, .byte_sent,
    .dfu_state, .rom_sel, .dfu_cmd, .in_ep_stall, .dev_addr
  );

  dfu_status_regs u_dfu_status_regs (
    .clk, .reset, .dfu_cmd, .status_addr, .status_byte, .dfu_state
  );

  descriptor_rom u_descriptor_rom (
    .clk, .reset, .rom_sel, .setup_stage_end, .byte_sent, .status_byte,
    .status_addr, .in_ep_data
  );

endmodule

`default_nettype wire
